/* logic/switch_pkg.sv */
`default_nettype none

package switch_pkg;

    // switch geometry
    localparam int num_ports = 4;
    localparam int num_prios = 4;
    // one page holds the largest packet
    localparam int page_words = 8;
    localparam int num_pages = 32;
    // almost_full once fewer free pages than this
    localparam int almost_full_level = 8;

    // header word layout
    localparam int hdr_dest_lsb = 0;
    localparam int hdr_prio_lsb = 2;
    localparam int hdr_len_lsb = 4;

    // one data word
    typedef logic [15:0] word_t;
    // whole packet, header in word 0
    typedef word_t [page_words-1:0] page_t;
    typedef logic [4:0] page_idx_t;
    typedef logic [1:0] port_idx_t;
    // 3 is highest
    typedef logic [1:0] prio_t;
    // packet length minus one
    typedef logic [2:0] len_t;
    // free page count, 0 up to num_pages
    typedef logic [$clog2(num_pages):0] page_cnt_t;

endpackage

`default_nettype wire

/* logic/store_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface store_if;
    import switch_pkg::*;

    // request with its payload, stable until granted
    logic req;
    port_idx_t dest;
    prio_t prio;
    page_t page;
    // single cycle, combinational in the arbiter
    logic grant;

    modport ingress (
        output req,
        output dest,
        output prio,
        output page,
        input grant
    );

    modport arbiter (
        input req,
        input dest,
        input prio,
        input page,
        output grant
    );

endinterface

`default_nettype wire

/* logic/port_ingress.sv */
`timescale 1ns/1ns
`default_nettype none

module port_ingress (
    input logic clk,
    input logic rst_n,
    input logic wr_sop,
    input logic wr_eop,
    input logic wr_vld,
    input switch_pkg::word_t wr_data,
    output logic pause,
    store_if.ingress st
);
    import switch_pkg::*;

    // staging page, one packet at a time
    page_t stage;
    // next word slot
    len_t wr_ptr;
    // packet complete, waiting for grant
    logic pending;
    logic accept;

    // words offered while a packet waits are dropped
    assign accept = wr_vld && !pending;

    always_ff @(posedge clk) begin
        if (accept) begin
            // header always lands in word 0
            stage[wr_sop ? len_t'(0) : wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
            wr_ptr <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_sop ? len_t'(1) : wr_ptr + len_t'(1);
            end
            // eop raises req, grant drops it at the same edge it is seen
            if (accept && wr_eop) begin
                pending <= 1'b1;
            end else if (st.grant) begin
                pending <= 1'b0;
            end
        end
    end

    // pause and req share one flag
    assign pause = pending;
    assign st.req = pending;

    // fields straight out of the stored header
    assign st.dest = stage[0][hdr_dest_lsb +: $bits(port_idx_t)];
    assign st.prio = stage[0][hdr_prio_lsb +: $bits(prio_t)];
    assign st.page = stage;

endmodule

`default_nettype wire

/* logic/store_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module store_arbiter (
    input logic clk,
    input logic rst_n,
    store_if.arbiter st [switch_pkg::num_ports],
    output logic [switch_pkg::num_ports-1:0] enq,
    output switch_pkg::prio_t enq_prio,
    output switch_pkg::page_idx_t enq_page,
    input logic [switch_pkg::num_ports-1:0] free_vld,
    input switch_pkg::page_idx_t free_page [switch_pkg::num_ports],
    output logic wr_en,
    output switch_pkg::page_idx_t wr_page_idx,
    output switch_pkg::page_t wr_page,
    output logic full,
    output logic almost_full
);
    import switch_pkg::*;

    // flattened view of the request buses
    logic [num_ports-1:0] req_vec;
    logic [num_ports-1:0] grant_vec;
    port_idx_t req_dest [num_ports];
    prio_t req_prio [num_ports];
    page_t req_page [num_ports];

    // round-robin start point
    port_idx_t rr_ptr;
    port_idx_t sel;
    logic sel_vld;

    // bit set means page in use
    logic [num_pages-1:0] used;
    logic [num_pages-1:0] clr_mask;
    page_idx_t free_idx;
    logic has_free;
    page_cnt_t free_cnt;
    page_cnt_t n_freed;
    logic do_store;

    for (genvar g = 0; g < num_ports; g++) begin : g_bus
        assign req_vec[g] = st[g].req;
        assign req_dest[g] = st[g].dest;
        assign req_prio[g] = st[g].prio;
        assign req_page[g] = st[g].page;
        assign st[g].grant = grant_vec[g];
    end

    // first requester at or after rr_ptr
    always_comb begin : rr_pick
        port_idx_t cand;
        sel = rr_ptr;
        sel_vld = 1'b0;
        for (int k = 0; k < num_ports; k++) begin
            cand = rr_ptr + port_idx_t'(k);
            if (!sel_vld && req_vec[cand]) begin
                sel = cand;
                sel_vld = 1'b1;
            end
        end
    end

    // lowest free page, scanning down so the lowest wins
    always_comb begin
        free_idx = '0;
        has_free = 1'b0;
        for (int i = num_pages - 1; i >= 0; i--) begin
            if (!used[i]) begin
                free_idx = page_idx_t'(i);
                has_free = 1'b1;
            end
        end
    end

    // pages returned by egress this cycle
    always_comb begin
        clr_mask = '0;
        n_freed = '0;
        for (int i = 0; i < num_ports; i++) begin
            if (free_vld[i]) begin
                clr_mask[free_page[i]] = 1'b1;
            end
            n_freed = n_freed + page_cnt_t'(free_vld[i]);
        end
    end

    // at most one store per cycle, held off while full reads high
    assign do_store = sel_vld && has_free && !full;

    always_comb begin
        grant_vec = '0;
        if (do_store) begin
            grant_vec[sel] = 1'b1;
        end
    end

    // buffer write happens at this cycle's edge
    assign wr_en = do_store;
    assign wr_page_idx = free_idx;
    assign wr_page = req_page[sel];

    always_ff @(posedge clk) begin
        if (do_store) begin
            enq_prio <= req_prio[sel];
            enq_page <= free_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
            used <= '0;
            free_cnt <= page_cnt_t'(num_pages);
            enq <= '0;
            full <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            // freed and taken pages never collide
            used <= (used & ~clr_mask) | (do_store ? (num_pages'(1) << free_idx) : '0);
            free_cnt <= free_cnt + n_freed - page_cnt_t'(do_store);
            enq <= '0;
            if (do_store) begin
                // destination decoded to one queue set
                enq[req_dest[sel]] <= 1'b1;
                rr_ptr <= sel + port_idx_t'(1);
            end
            // flags trail the bitmap by one cycle
            full <= free_cnt == '0;
            almost_full <= free_cnt < page_cnt_t'(almost_full_level);
        end
    end

endmodule

`default_nettype wire

/* logic/packet_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module packet_buffer (
    input logic clk,
    input logic wr_en,
    input switch_pkg::page_idx_t wr_page_idx,
    input switch_pkg::page_t wr_page,
    input logic link_en,
    input switch_pkg::page_idx_t link_from,
    input switch_pkg::page_idx_t link_to,
    input switch_pkg::page_idx_t rd_idx [switch_pkg::num_ports],
    output switch_pkg::page_t rd_page [switch_pkg::num_ports],
    input switch_pkg::page_idx_t next_idx [switch_pkg::num_ports],
    output switch_pkg::page_idx_t next_page [switch_pkg::num_ports]
);
    import switch_pkg::*;

    // whole packets, one per page
    page_t data_mem [num_pages];
    // queue order, page to following page
    page_idx_t link_mem [num_pages];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_page_idx] <= wr_page;
        end
    end

    always_ff @(posedge clk) begin
        if (link_en) begin
            link_mem[link_from] <= link_to;
        end
    end

    // asynchronous reads, one pair per output port
    for (genvar g = 0; g < num_ports; g++) begin : g_rd
        assign rd_page[g] = data_mem[rd_idx[g]];
        assign next_page[g] = link_mem[next_idx[g]];
    end

endmodule

`default_nettype wire

/* logic/port_queues.sv */
`timescale 1ns/1ns
`default_nettype none

module port_queues (
    input logic clk,
    input logic rst_n,
    input logic enq,
    input switch_pkg::prio_t enq_prio,
    input switch_pkg::page_idx_t enq_page,
    input logic take,
    output logic avail,
    output switch_pkg::page_idx_t head_page,
    output logic link_en,
    output switch_pkg::page_idx_t link_from,
    output switch_pkg::page_idx_t link_to,
    output switch_pkg::page_idx_t next_idx,
    input switch_pkg::page_idx_t next_page
);
    import switch_pkg::*;

    page_idx_t head [num_prios];
    page_idx_t tail [num_prios];
    logic [num_prios-1:0] empty;
    // priority served next
    prio_t sel;
    logic [num_prios-1:0] enq_hit;
    logic [num_prios-1:0] take_hit;

    // strict priority, highest non-empty wins
    always_comb begin
        sel = '0;
        for (int p = 0; p < num_prios; p++) begin
            if (!empty[p]) begin
                sel = prio_t'(p);
            end
        end
    end

    always_comb begin
        enq_hit = '0;
        take_hit = '0;
        enq_hit[enq_prio] = enq;
        take_hit[sel] = take;
    end

    assign avail = ~&empty;
    assign head_page = head[sel];
    // successor of the head being taken
    assign next_idx = head[sel];

    // old tail points at the new page
    // zeroed when idle so the four ports can be ORed
    assign link_en = enq && !empty[enq_prio];
    assign link_from = link_en ? tail[enq_prio] : '0;
    assign link_to = link_en ? enq_page : '0;

    always_ff @(posedge clk) begin
        for (int p = 0; p < num_prios; p++) begin
            if (enq_hit[p]) begin
                tail[p] <= enq_page;
            end
            if (enq_hit[p] && empty[p]) begin
                head[p] <= enq_page;
            end else if (take_hit[p]) begin
                // last one out, head follows a same-cycle enq
                head[p] <= (head[p] == tail[p]) ? enq_page : next_page;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            empty <= '1;
        end else begin
            for (int p = 0; p < num_prios; p++) begin
                if (take_hit[p] && head[p] == tail[p]) begin
                    empty[p] <= !enq_hit[p];
                end else if (enq_hit[p]) begin
                    empty[p] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/port_egress.sv */
`timescale 1ns/1ns
`default_nettype none

module port_egress (
    input logic clk,
    input logic rst_n,
    input logic ready,
    input logic avail,
    output logic take,
    input switch_pkg::page_idx_t page_idx,
    input switch_pkg::page_t page_data,
    output logic free_vld,
    output switch_pkg::page_idx_t free_page,
    output logic rd_sop,
    output logic rd_eop,
    output logic rd_vld,
    output switch_pkg::word_t rd_data
);
    import switch_pkg::*;

    // local copy, so the page can go back at once
    page_t pkt;
    len_t last_word;
    len_t word_cnt;
    // words still to send after the current one
    logic busy;
    len_t hdr_len;

    assign hdr_len = page_data[0][hdr_len_lsb +: $bits(len_t)];
    // ready only matters between packets
    assign take = !busy && ready && avail;

    always_ff @(posedge clk) begin
        if (take) begin
            pkt <= page_data;
            last_word <= hdr_len;
            free_page <= page_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            word_cnt <= '0;
            free_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
            rd_vld <= 1'b0;
            rd_data <= '0;
        end else begin
            free_vld <= take;
            rd_sop <= take;
            if (take) begin
                // header goes out straight from the buffer read
                rd_vld <= 1'b1;
                rd_data <= page_data[0];
                rd_eop <= hdr_len == '0;
                busy <= hdr_len != '0;
                word_cnt <= len_t'(1);
            end else if (busy) begin
                rd_vld <= 1'b1;
                rd_data <= pkt[word_cnt];
                rd_eop <= word_cnt == last_word;
                busy <= word_cnt != last_word;
                word_cnt <= word_cnt + len_t'(1);
            end else begin
                rd_vld <= 1'b0;
                rd_eop <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/switch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module switch_top (
    input logic clk,
    input logic rst_n,
    input logic [switch_pkg::num_ports-1:0] wr_sop,
    input logic [switch_pkg::num_ports-1:0] wr_eop,
    input logic [switch_pkg::num_ports-1:0] wr_vld,
    input switch_pkg::word_t [switch_pkg::num_ports-1:0] wr_data,
    output logic [switch_pkg::num_ports-1:0] pause,
    output logic full,
    output logic almost_full,
    input logic [switch_pkg::num_ports-1:0] ready,
    output logic [switch_pkg::num_ports-1:0] rd_sop,
    output logic [switch_pkg::num_ports-1:0] rd_eop,
    output logic [switch_pkg::num_ports-1:0] rd_vld,
    output switch_pkg::word_t [switch_pkg::num_ports-1:0] rd_data
);
    import switch_pkg::*;

    // ingress to arbiter
    store_if st_bus [num_ports] ();

    // arbiter to queues
    logic [num_ports-1:0] enq;
    prio_t enq_prio;
    page_idx_t enq_page;

    // egress back to arbiter
    logic [num_ports-1:0] free_vld;
    page_idx_t free_page [num_ports];

    // page write
    logic wr_en;
    page_idx_t wr_page_idx;
    page_t wr_page;

    // per-port link writes and their OR
    logic [num_ports-1:0] q_link_en;
    page_idx_t q_link_from [num_ports];
    page_idx_t q_link_to [num_ports];
    logic link_en;
    page_idx_t link_from;
    page_idx_t link_to;

    // queues to egress and buffer reads
    logic [num_ports-1:0] avail;
    logic [num_ports-1:0] take;
    page_idx_t head_page [num_ports];
    page_t rd_page [num_ports];
    page_idx_t next_idx [num_ports];
    page_idx_t next_page [num_ports];

    // one enq per cycle, so at most one port drives a link
    always_comb begin
        link_from = '0;
        link_to = '0;
        for (int i = 0; i < num_ports; i++) begin
            link_from = link_from | q_link_from[i];
            link_to = link_to | q_link_to[i];
        end
    end
    assign link_en = |q_link_en;

    store_arbiter u_store_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .st(st_bus),
        .enq(enq),
        .enq_prio(enq_prio),
        .enq_page(enq_page),
        .free_vld(free_vld),
        .free_page(free_page),
        .wr_en(wr_en),
        .wr_page_idx(wr_page_idx),
        .wr_page(wr_page),
        .full(full),
        .almost_full(almost_full)
    );

    packet_buffer u_packet_buffer (
        .clk(clk),
        .wr_en(wr_en),
        .wr_page_idx(wr_page_idx),
        .wr_page(wr_page),
        .link_en(link_en),
        .link_from(link_from),
        .link_to(link_to),
        .rd_idx(head_page),
        .rd_page(rd_page),
        .next_idx(next_idx),
        .next_page(next_page)
    );

    for (genvar g = 0; g < num_ports; g++) begin : g_port
        port_ingress u_port_ingress (
            .clk(clk),
            .rst_n(rst_n),
            .wr_sop(wr_sop[g]),
            .wr_eop(wr_eop[g]),
            .wr_vld(wr_vld[g]),
            .wr_data(wr_data[g]),
            .pause(pause[g]),
            .st(st_bus[g])
        );

        port_queues u_port_queues (
            .clk(clk),
            .rst_n(rst_n),
            .enq(enq[g]),
            .enq_prio(enq_prio),
            .enq_page(enq_page),
            .take(take[g]),
            .avail(avail[g]),
            .head_page(head_page[g]),
            .link_en(q_link_en[g]),
            .link_from(q_link_from[g]),
            .link_to(q_link_to[g]),
            .next_idx(next_idx[g]),
            .next_page(next_page[g])
        );

        port_egress u_port_egress (
            .clk(clk),
            .rst_n(rst_n),
            .ready(ready[g]),
            .avail(avail[g]),
            .take(take[g]),
            .page_idx(head_page[g]),
            .page_data(rd_page[g]),
            .free_vld(free_vld[g]),
            .free_page(free_page[g]),
            .rd_sop(rd_sop[g]),
            .rd_eop(rd_eop[g]),
            .rd_vld(rd_vld[g]),
            .rd_data(rd_data[g])
        );
    end

endmodule

`default_nettype wire

/* test/switch_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module switch_asserts (
    input logic clk,
    input logic rst_n,
    input logic [switch_pkg::num_ports-1:0] req,
    input logic [switch_pkg::num_ports-1:0] grant,
    input logic full
);
    import switch_pkg::*;

    // at most one store per cycle
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else $error("store grant is not one-hot");

    // no store once the buffer reads full
    a_no_grant_full: assert property (@(posedge clk) disable iff (!rst_n) full |-> grant == '0)
        else $error("store granted while the buffer is full");

    // a request waits for its grant
    for (genvar g = 0; g < num_ports; g++) begin : g_req
        a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
            req[g] && !grant[g] |=> req[g])
            else $error("store request on port %0d dropped before its grant", g);
    end

endmodule

bind store_arbiter switch_asserts u_switch_asserts (
    .clk(clk),
    .rst_n(rst_n),
    .req(req_vec),
    .grant(grant_vec),
    .full(full)
);

`default_nettype wire

/* test/switch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module switch_tb;
    import switch_pkg::*;

    localparam int num_rows = 27;
    localparam int max_pkts = 64;
    // output port held back in the priority test
    localparam int slow_port = 2;

    // columns: source, dest, priority, length, phase, ready-hold mask, repeat count
    // phase 1 single lengths, 2 mixed sources, 3 priority order, 4 fill
    localparam int pkt_table [num_rows][7] = '{
        '{0, 0, 1, 1, 1, 0, 1}, '{0, 1, 2, 2, 1, 0, 1}, '{0, 2, 0, 3, 1, 0, 1},
        '{0, 3, 3, 4, 1, 0, 1}, '{0, 0, 2, 5, 1, 0, 1}, '{0, 1, 0, 6, 1, 0, 1},
        '{0, 2, 1, 7, 1, 0, 1}, '{0, 3, 2, 8, 1, 0, 1},
        '{0, 2, 0, 3, 2, 0, 1}, '{1, 2, 3, 8, 2, 0, 1}, '{2, 2, 1, 1, 2, 0, 1},
        '{3, 0, 2, 5, 2, 0, 1}, '{0, 1, 3, 6, 2, 0, 1}, '{1, 3, 0, 2, 2, 0, 1},
        '{2, 0, 0, 4, 2, 0, 1}, '{3, 2, 3, 7, 2, 0, 1}, '{0, 3, 1, 8, 2, 0, 1},
        '{1, 0, 2, 1, 2, 0, 1}, '{2, 2, 2, 5, 2, 0, 1}, '{3, 1, 1, 3, 2, 0, 1},
        '{1, 2, 0, 4, 3, 4, 1}, '{1, 2, 3, 6, 3, 4, 1},
        '{0, 1, 0, 5, 4, 15, 8}, '{1, 2, 1, 3, 4, 15, 8}, '{2, 3, 2, 8, 4, 15, 8},
        '{3, 0, 3, 2, 4, 15, 8}, '{0, 2, 3, 4, 4, 15, 1}
    };

    logic clk;
    logic rst_n;
    logic [num_ports-1:0] wr_sop;
    logic [num_ports-1:0] wr_eop;
    logic [num_ports-1:0] wr_vld;
    word_t [num_ports-1:0] wr_data;
    logic [num_ports-1:0] pause;
    logic full;
    logic almost_full;
    logic [num_ports-1:0] ready;
    logic [num_ports-1:0] rd_sop;
    logic [num_ports-1:0] rd_eop;
    logic [num_ports-1:0] rd_vld;
    word_t [num_ports-1:0] rd_data;

    // expanded packets
    word_t pkt_words [max_pkts][page_words];
    int pkt_len [max_pkts];
    int pkt_src [max_pkts];
    int pkt_dest [max_pkts];
    int pkt_prio [max_pkts];
    int pkt_phase [max_pkts];
    int pkt_hold [max_pkts];
    int n_pkts;

    // per source sender
    int send_q [num_ports][$];
    int cur_pkt [num_ports];
    int word_idx [num_ports];
    logic [num_ports-1:0] waiting;
    logic [num_ports-1:0] pause_d;

    // scoreboard, one FIFO per output port and priority
    int exp_q [num_ports*num_prios][$];
    word_t rx_words [num_ports][page_words];
    int rx_len [num_ports];
    logic [num_ports-1:0] rx_busy;

    logic [15:0] lfsr;
    string test_name;
    int value_errors;
    int protocol_errors;
    int stored;
    logic flag_check;
    int cycles;
    int cycle_limit;

    switch_top u_switch_top (
        .clk(clk),
        .rst_n(rst_n),
        .wr_sop(wr_sop),
        .wr_eop(wr_eop),
        .wr_vld(wr_vld),
        .wr_data(wr_data),
        .pause(pause),
        .full(full),
        .almost_full(almost_full),
        .ready(ready),
        .rd_sop(rd_sop),
        .rd_eop(rd_eop),
        .rd_vld(rd_vld),
        .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, shifting right
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int nbits, output word_t val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val = {val[14:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic build_packets();
        word_t w;
        word_t hdr;
        int id;
        n_pkts = 0;
        for (int r = 0; r < num_rows; r++) begin
            for (int c = 0; c < pkt_table[r][6]; c++) begin
                id = n_pkts;
                pkt_src[id] = pkt_table[r][0];
                pkt_dest[id] = pkt_table[r][1];
                pkt_prio[id] = pkt_table[r][2];
                pkt_len[id] = pkt_table[r][3];
                pkt_phase[id] = pkt_table[r][4];
                pkt_hold[id] = pkt_table[r][5];
                // header, random bits above the three fields
                draw_bits(9, w);
                hdr = '0;
                hdr[15:7] = w[8:0];
                hdr[hdr_dest_lsb +: 2] = port_idx_t'(pkt_dest[id]);
                hdr[hdr_prio_lsb +: 2] = prio_t'(pkt_prio[id]);
                hdr[hdr_len_lsb +: 3] = len_t'(pkt_len[id] - 1);
                pkt_words[id][0] = hdr;
                for (int i = 1; i < pkt_len[id]; i++) begin
                    draw_bits(16, w);
                    pkt_words[id][i] = w;
                end
                n_pkts++;
            end
        end
    endtask

    task automatic report_mismatch(input string what, input int exp, input int act);
        value_errors++;
        $display("Error %s %s: expected 0x%0h actual 0x%0h", test_name, what, exp, act);
    endtask

    task automatic report_protocol(input string msg);
        protocol_errors++;
        $display("%s during %s", msg, test_name);
    endtask

    task automatic compare_packet(input int p);
        prio_t prio;
        int q;
        int id;
        prio = rx_words[p][0][hdr_prio_lsb +: $bits(prio_t)];
        q = p * num_prios + int'(prio);
        if (exp_q[q].size() == 0) begin
            report_protocol($sformatf("unexpected packet on port %0d priority %0d", p, prio));
        end else begin
            id = exp_q[q].pop_front();
            if (rx_len[p] != pkt_len[id]) begin
                report_mismatch($sformatf("port %0d length", p), pkt_len[id], rx_len[p]);
            end
            for (int i = 0; i < page_words; i++) begin
                if (i < pkt_len[id] && i < rx_len[p] && rx_words[p][i] !== pkt_words[id][i]) begin
                    report_mismatch($sformatf("port %0d word %0d", p, i),
                        int'(pkt_words[id][i]), int'(rx_words[p][i]));
                end
            end
        end
    endtask

    // flags trail the store count by one cycle
    task automatic check_flags();
        if (flag_check) begin
            if (almost_full !== (stored > num_pages - almost_full_level)) begin
                report_mismatch("almost_full", int'(stored > num_pages - almost_full_level),
                    int'(almost_full));
            end
            if (full !== (stored >= num_pages)) begin
                report_mismatch("full", int'(stored >= num_pages), int'(full));
            end
        end
    endtask

    // pause falling means the waiting packet was stored
    task automatic note_stores();
        int id;
        for (int p = 0; p < num_ports; p++) begin
            if (pause_d[p] && !pause[p]) begin
                if (!waiting[p]) begin
                    report_protocol($sformatf("pause fell on port %0d with no packet", p));
                end else begin
                    id = cur_pkt[p];
                    exp_q[pkt_dest[id] * num_prios + pkt_prio[id]].push_back(id);
                    waiting[p] = 1'b0;
                    stored++;
                end
            end
        end
        pause_d = pause;
    endtask

    task automatic watch_outputs();
        for (int p = 0; p < num_ports; p++) begin
            if (!rd_vld[p] && (rd_sop[p] || rd_eop[p])) begin
                report_protocol($sformatf("sop or eop without vld on port %0d", p));
            end
            if (rd_vld[p]) begin
                if (rd_sop[p]) begin
                    if (rx_busy[p]) begin
                        report_protocol($sformatf("sop inside a packet on port %0d", p));
                    end
                    rx_busy[p] = 1'b1;
                    rx_len[p] = 0;
                end else if (!rx_busy[p]) begin
                    report_protocol($sformatf("data word without sop on port %0d", p));
                end
                if (rx_busy[p]) begin
                    rx_words[p][rx_len[p]] = rd_data[p];
                    rx_len[p]++;
                    if (rd_eop[p]) begin
                        compare_packet(p);
                        rx_busy[p] = 1'b0;
                    end else if (rx_len[p] >= page_words) begin
                        report_protocol($sformatf("no eop after a full page on port %0d", p));
                        rx_busy[p] = 1'b0;
                    end
                end
            end else if (rx_busy[p]) begin
                report_protocol($sformatf("rd_vld dropped inside a packet on port %0d", p));
                rx_busy[p] = 1'b0;
            end
        end
    endtask

    task automatic drive_inputs();
        int id;
        wr_sop = '0;
        wr_eop = '0;
        wr_vld = '0;
        wr_data = '0;
        for (int p = 0; p < num_ports; p++) begin
            // a finished packet holds the port until stored
            if (!waiting[p] && !pause[p]) begin
                if (word_idx[p] < 0 && send_q[p].size() > 0) begin
                    cur_pkt[p] = send_q[p].pop_front();
                    word_idx[p] = 0;
                end
                if (word_idx[p] >= 0) begin
                    id = cur_pkt[p];
                    wr_vld[p] = 1'b1;
                    wr_sop[p] = word_idx[p] == 0;
                    wr_data[p] = pkt_words[id][word_idx[p]];
                    if (word_idx[p] == pkt_len[id] - 1) begin
                        wr_eop[p] = 1'b1;
                        word_idx[p] = -1;
                        waiting[p] = 1'b1;
                    end else begin
                        word_idx[p]++;
                    end
                end
            end
        end
    endtask

    // sample and drive 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
        check_flags();
        note_stores();
        watch_outputs();
        drive_inputs();
    endtask

    function automatic bit sends_pending();
        bit busy;
        busy = 1'b0;
        for (int p = 0; p < num_ports; p++) begin
            if (send_q[p].size() > 0 || word_idx[p] >= 0 || waiting[p]) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    function automatic bit words_pending();
        bit busy;
        busy = 1'b0;
        for (int p = 0; p < num_ports; p++) begin
            if (send_q[p].size() > 0 || word_idx[p] >= 0) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    function automatic bit outputs_pending();
        bit busy;
        busy = |rx_busy;
        for (int q = 0; q < num_ports * num_prios; q++) begin
            if (exp_q[q].size() > 0) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    task automatic load_phase(input int ph);
        bit first;
        first = 1'b1;
        for (int id = 0; id < n_pkts; id++) begin
            if (pkt_phase[id] == ph) begin
                send_q[pkt_src[id]].push_back(id);
                if (first) begin
                    ready = ~num_ports'(pkt_hold[id]);
                    first = 1'b0;
                end
            end
        end
    endtask

    task automatic wait_drain();
        while (sends_pending() || outputs_pending()) begin
            step();
        end
        repeat (4) step();
    endtask

    initial begin : watchdog
        cycles = 0;
        @(posedge clk);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, traffic still pending after %0d cycles", cycles);
        $display("%0d value errors, %0d protocol errors", value_errors, protocol_errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        wr_sop = '0;
        wr_eop = '0;
        wr_vld = '0;
        wr_data = '0;
        ready = '0;
        lfsr = 16'd31;
        value_errors = 0;
        protocol_errors = 0;
        stored = 0;
        flag_check = 1'b0;
        waiting = '0;
        pause_d = '0;
        rx_busy = '0;
        for (int p = 0; p < num_ports; p++) begin
            word_idx[p] = -1;
            cur_pkt[p] = 0;
            rx_len[p] = 0;
        end
        build_packets();
        cycle_limit = n_pkts * (page_words + 10) + 200;
        test_name = "reset";
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();
        if (pause !== '0 || rd_vld !== '0 || full !== 1'b0 || almost_full !== 1'b0) begin
            report_protocol("outputs not idle after reset");
        end

        test_name = "single_lengths";
        load_phase(1);
        wait_drain();

        test_name = "mixed_sources";
        load_phase(2);
        wait_drain();

        // low priority stored first, high priority must leave first
        test_name = "priority_order";
        load_phase(3);
        while (sends_pending()) begin
            step();
        end
        repeat (10) step();
        ready = '1;
        while (!rd_sop[slow_port]) begin
            step();
        end
        if (rd_data[slow_port][hdr_prio_lsb +: $bits(prio_t)] !== prio_t'(3)) begin
            report_mismatch("first priority out", 3,
                int'(rd_data[slow_port][hdr_prio_lsb +: $bits(prio_t)]));
        end
        wait_drain();

        // every ready low, 33 packets for 32 pages
        test_name = "fill_flags";
        stored = 0;
        flag_check = 1'b1;
        load_phase(4);
        while (words_pending() || stored < num_pages) begin
            step();
        end
        repeat (4) step();
        if (full !== 1'b1) begin
            report_mismatch("full", 1, int'(full));
        end
        if (almost_full !== 1'b1) begin
            report_mismatch("almost_full", 1, int'(almost_full));
        end
        repeat (10) step();
        if ($countones(pause) != 1) begin
            report_protocol("extra packet not held by pause while full");
        end
        flag_check = 1'b0;

        // the held packet must come out too
        test_name = "drain";
        ready = '1;
        wait_drain();
        if (full !== 1'b0) begin
            report_mismatch("full", 0, int'(full));
        end
        if (almost_full !== 1'b0) begin
            report_mismatch("almost_full", 0, int'(almost_full));
        end

        $display("%0d value errors, %0d protocol errors", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
logic/switch_pkg.sv
logic/store_if.sv
logic/port_ingress.sv
logic/store_arbiter.sv
logic/packet_buffer.sv
logic/port_queues.sv
logic/port_egress.sv
logic/switch_top.sv
test/switch_asserts.sv
test/switch_tb.sv

/* run.sh */
#!/bin/sh
# build the switch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module switch_tb \
    -Mdir obj_dir -o switch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/switch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
